/* Bender.yml */
package:
  name: nes_cpu_bus

sources:
  - hdl/nes_bus_pkg.sv
  - hdl/ctlr_interface.sv
  - hdl/bus_arbiter.sv
  - hdl/cpu_memory_map.sv
  - hdl/oam_dma.sv
  - hdl/nes_cpu_bus.sv
  - target: simulation
    files:
      - bench/nes_bus_properties.sv
      - bench/tb_nes_cpu_bus.sv

/* bench/nes_bus_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module nes_bus_properties (
    input logic clock,
    input logic reset_n,
    input logic cpu_req,
    input logic cpu_ack,
    input logic dma_req,
    input logic dma_ack,
    input logic ctlr_latch,
    input logic ctlr_pulse,
    input nes_bus_pkg::ppu_port_t ppu
);

    // Ack may outlive req, but only rises on a live request
    cpu_ack_has_req: assert property (
        @(posedge clock) disable iff (!reset_n) $rose(cpu_ack) |-> $past(cpu_req)
    ) else $error("cpu_ack rose without cpu_req");

    dma_ack_has_req: assert property (
        @(posedge clock) disable iff (!reset_n) $rose(dma_ack) |-> $past(dma_req)
    ) else $error("dma_ack rose without dma_req");

    one_ack: assert property (
        @(posedge clock) disable iff (!reset_n) !(cpu_ack && dma_ack)
    ) else $error("cpu_ack and dma_ack high together");

    pad_pins: assert property (
        @(posedge clock) disable iff (!reset_n) !(ctlr_latch && ctlr_pulse)
    ) else $error("ctlr_latch and ctlr_pulse high together");

    ppu_en_single: assert property (
        @(posedge clock) disable iff (!reset_n) ppu.en |=> !ppu.en
    ) else $error("PPU enable held for more than one cycle");

endmodule

bind nes_cpu_bus nes_bus_properties u_properties (
    .clock(clock),
    .reset_n(reset_n),
    .cpu_req(cpu_req),
    .cpu_ack(cpu_ack),
    .dma_req(dma_req),
    .dma_ack(dma_ack),
    .ctlr_latch(ctlr_latch),
    .ctlr_pulse(ctlr_pulse),
    .ppu(ppu)
);

`default_nettype wire

/* bench/tb_nes_cpu_bus.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_nes_cpu_bus;

    logic clock;
    logic reset_n;
    logic cpu_req;
    nes_bus_pkg::bus_req_t cpu_cmd;
    logic cpu_ack;
    logic [7:0] cpu_rdata;
    nes_bus_pkg::ppu_port_t ppu;
    logic [7:0] ppu_rdata;
    logic ctlr_data;
    logic ctlr_pulse;
    logic ctlr_latch;
    logic dma_busy;

    integer seed;
    int check_count;
    int error_count;
    int timeout_count;
    logic busy_at_ack;

    // Reference state
    logic [7:0] shadow_ram [2048];
    logic [7:0] buttons;
    int pad_index;
    logic [15:0] ram_addrs [64];

    // PPU model
    logic [7:0] ppu_regs [8] = '{default: 8'h00};
    nes_bus_pkg::ppu_port_t ppu_seen = '0;
    logic [7:0] oam_log [$];

    // Joypad model
    logic [7:0] pad_shift = 8'h00;
    logic pulse_q = 1'b0;

    // Finished reads waiting for the compare process
    string label_q [$];
    logic [7:0] got_q [$];
    logic [7:0] exp_q [$];

    nes_cpu_bus u_dut (
        .clock(clock),
        .reset_n(reset_n),
        .cpu_req(cpu_req),
        .cpu_cmd(cpu_cmd),
        .cpu_ack(cpu_ack),
        .cpu_rdata(cpu_rdata),
        .ppu(ppu),
        .ppu_rdata(ppu_rdata),
        .ctlr_data(ctlr_data),
        .ctlr_pulse(ctlr_pulse),
        .ctlr_latch(ctlr_latch),
        .dma_busy(dma_busy)
    );

    always #4 clock = ~clock;

    // PPU answers in the strobe cycle
    assign ppu_rdata = ppu_regs[ppu.sel];

    always @(negedge clock) begin
        if (ppu.en) begin
            ppu_seen <= ppu;
            if (ppu.write) begin
                ppu_regs[ppu.sel] <= ppu.wdata;
                if (ppu.sel == nes_bus_pkg::oamdata) begin
                    oam_log.push_back(ppu.wdata);
                end
            end
        end
    end

    // Pressed button pulls the serial line low
    assign ctlr_data = ~pad_shift[0];

    always @(negedge clock) begin
        pulse_q <= ctlr_pulse;
        if (ctlr_latch) begin
            pad_shift <= buttons;
        end else if (ctlr_pulse && !pulse_q) begin
            pad_shift <= {1'b0, pad_shift[7:1]};
        end
    end

    function automatic logic [7:0] expected_read(input logic [15:0] addr);
        if (addr < 16'h2000) begin
            return shadow_ram[int'(addr % 16'h0800)];
        end else if (addr < 16'h4000) begin
            return ppu_regs[int'(addr % 16'd8)];
        end else if (addr == 16'h4016) begin
            return {7'b0, buttons[pad_index]};
        end else begin
            return 8'h00;
        end
    endfunction

    task automatic check_rdata(input string what, input logic [7:0] got,
                               input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s got %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_ppu(input string what, input nes_bus_pkg::ppu_port_t got,
                             input nes_bus_pkg::ppu_port_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s got en=%0b write=%0b sel=%0d data=%02h, %s",
                     $time, what, got.en, got.write, got.sel, got.wdata,
                     $sformatf("expected en=%0b write=%0b sel=%0d data=%02h",
                               exp.en, exp.write, exp.sel, exp.wdata));
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        timeout_count++;
        finish_run();
    endtask

    // One four-phase transaction on the CPU channel
    task automatic cpu_access(input logic [15:0] addr, input logic write,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        int cycles;
        @(negedge clock);
        cpu_cmd.addr.flat = addr;
        cpu_cmd.write = write;
        cpu_cmd.wdata = wdata;
        cpu_req = 1'b1;
        cycles = 0;
        while (!cpu_ack) begin
            @(negedge clock);
            cycles++;
            if (cycles > 8000) begin
                abort_run($sformatf("cpu_ack never rose for address %04h", addr));
            end
        end
        rdata = cpu_rdata;
        busy_at_ack = dma_busy;
        cpu_req = 1'b0;
        cycles = 0;
        while (cpu_ack) begin
            @(negedge clock);
            cycles++;
            if (cycles > 16) begin
                abort_run($sformatf("cpu_ack stayed high after the access to %04h", addr));
            end
        end
    endtask

    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] ignored;
        if (addr < 16'h2000) begin
            shadow_ram[int'(addr % 16'h0800)] = data;
        end
        cpu_access(addr, 1'b1, data, ignored);
    endtask

    task automatic cpu_read(input logic [15:0] addr);
        logic [7:0] exp;
        logic [7:0] got;
        exp = expected_read(addr);
        cpu_access(addr, 1'b0, 8'h00, got);
        label_q.push_back($sformatf("read %04h", addr));
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    task automatic wait_pulse();
        int cycles;
        cycles = 0;
        while (!ctlr_pulse) begin
            @(negedge clock);
            cycles++;
            if (cycles > 32) begin
                abort_run("ctlr_pulse never rose after a joypad read");
            end
        end
        cycles = 0;
        while (ctlr_pulse) begin
            @(negedge clock);
            cycles++;
            if (cycles > 32) begin
                abort_run("ctlr_pulse never fell after a joypad read");
            end
        end
    endtask

    task automatic drain_reads();
        int cycles;
        cycles = 0;
        while (got_q.size() > 0) begin
            @(negedge clock);
            cycles++;
            if (cycles > 8) begin
                abort_run("compare process left reads unchecked");
            end
        end
    endtask

    // Compare process
    always @(posedge clock) begin
        while (got_q.size() > 0) begin
            check_rdata(label_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
        end
    end

    initial begin
        logic [7:0] data;
        logic [7:0] page;
        logic [15:0] addr;
        logic pulse_seen;
        nes_bus_pkg::ppu_port_t ppu_exp;

        seed = 32'h36495a89;
        clock = 1'b0;
        reset_n = 1'b0;
        cpu_req = 1'b0;
        cpu_cmd = '0;
        buttons = 8'h00;
        pad_index = 0;
        check_count = 0;
        error_count = 0;
        timeout_count = 0;
        busy_at_ack = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        // Everything idle out of reset
        check_level("cpu_ack", cpu_ack, 1'b0);
        check_level("dma_ack", u_dut.dma_ack, 1'b0);
        check_level("mem_strobe", u_dut.mem_strobe, 1'b0);
        check_level("dma_req", u_dut.dma_req, 1'b0);
        check_level("dma_busy", dma_busy, 1'b0);
        check_level("ctlr_latch", ctlr_latch, 1'b0);
        check_level("ctlr_pulse", ctlr_pulse, 1'b0);
        ppu_exp = '0;
        check_ppu("ppu port after reset", ppu, ppu_exp);

        cpu_read(16'h5000);
        cpu_read(16'h4014);
        cpu_read(16'h4017);
        cpu_read(16'hffff);

        // Work RAM read back through a random mirror
        for (int i = 0; i < 64; i++) begin
            addr = 16'($random(seed)) & 16'h1fff;
            ram_addrs[i] = addr;
            cpu_write(addr, 8'($random(seed)));
        end
        for (int i = 0; i < 64; i++) begin
            addr = {3'b000, 2'($random(seed)), ram_addrs[i][10:0]};
            cpu_read(addr);
        end

        for (int i = 0; i < 16; i++) begin
            addr = 16'h2000 | (16'($random(seed)) & 16'h1fff);
            data = 8'($random(seed));
            cpu_write(addr, data);
            ppu_exp.en = 1'b1;
            ppu_exp.write = 1'b1;
            ppu_exp.sel = nes_bus_pkg::ppu_reg_t'(3'(addr % 16'd8));
            ppu_exp.wdata = data;
            check_ppu($sformatf("ppu write %04h", addr), ppu_seen, ppu_exp);
            cpu_read(16'h2000 | (16'($random(seed)) & 16'h1ff8) | (addr % 16'd8));
        end

        buttons = 8'($random(seed));
        cpu_write(16'h4016, 8'h01);
        check_level("ctlr_latch after writing 1", ctlr_latch, 1'b1);
        cpu_write(16'h4016, 8'h00);
        for (int i = 0; i < 8; i++) begin
            pad_index = i;
            cpu_read(16'h4016);
            wait_pulse();
        end

        // No pulse on a ninth read once the pad machine is idle
        cpu_access(16'h4016, 1'b0, 8'h00, data);
        pulse_seen = 1'b0;
        for (int i = 0; i < 2 * (nes_bus_pkg::ctlr_pulse_len + 1); i++) begin
            @(negedge clock);
            pulse_seen = pulse_seen | ctlr_pulse;
        end
        check_level("ctlr_pulse after a ninth read", pulse_seen, 1'b0);

        // OAM DMA from a random RAM page
        page = 8'($random(seed)) & 8'h1f;
        for (int i = 0; i < 256; i++) begin
            cpu_write({page, 8'(i)}, 8'($random(seed)));
        end
        oam_log.delete();
        cpu_write(16'h4014, page);
        check_level("dma_busy after writing 4014h", dma_busy, 1'b1);
        cpu_read({page, 8'($random(seed))});
        check_level("dma_busy when the CPU read was acked", busy_at_ack, 1'b0);
        if (oam_log.size() != 256) begin
            error_count++;
            $display("OAM log holds %0d bytes after the DMA instead of 256", oam_log.size());
        end else begin
            for (int i = 0; i < 256; i++) begin
                check_rdata($sformatf("oam byte %0d", i), oam_log[i],
                            shadow_ram[int'({page, 8'(i)} % 16'h0800)]);
            end
        end

        drain_reads();
        finish_run();
    end

endmodule

`default_nettype wire

/* hdl/bus_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
    input logic clock,
    input logic reset_n,

    input logic cpu_req,
    input nes_bus_pkg::bus_req_t cpu_cmd,
    output logic cpu_ack,
    output logic [7:0] cpu_rdata,

    input logic dma_req,
    input nes_bus_pkg::bus_req_t dma_cmd,
    output logic dma_ack,
    output logic [7:0] dma_rdata,

    output nes_bus_pkg::bus_req_t mem_cmd,
    output logic mem_strobe,
    input logic [7:0] mem_rdata
);

    typedef enum logic [1:0] {st_idle, st_access, st_respond, st_release} state_t;

    state_t state;
    logic grant_dma;
    logic dma_hold;
    logic ack_q;
    logic granted_req;
    logic [7:0] rdata_q;

    assign granted_req = grant_dma ? dma_req : cpu_req;
    assign mem_cmd = grant_dma ? dma_cmd : cpu_cmd;
    assign mem_strobe = (state == st_access);

    assign cpu_ack = ack_q && !grant_dma;
    assign dma_ack = ack_q && grant_dma;
    assign cpu_rdata = rdata_q;
    assign dma_rdata = rdata_q;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
            grant_dma <= 1'b0;
            dma_hold <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    // DMA re-requests one cycle after its ack falls, keep the slot for it
                    dma_hold <= 1'b0;
                    if (dma_req) begin
                        grant_dma <= 1'b1;
                        state <= st_access;
                    end else if (cpu_req && !dma_hold) begin
                        grant_dma <= 1'b0;
                        state <= st_access;
                    end
                end
                st_access: begin
                    state <= st_respond;
                end
                st_respond: begin
                    ack_q <= 1'b1;
                    state <= st_release;
                end
                st_release: begin
                    if (!granted_req) begin
                        ack_q <= 1'b0;
                        dma_hold <= grant_dma;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Read data from the memory map lands one cycle after the strobe
    always_ff @(posedge clock) begin
        if (state == st_respond) begin
            rdata_q <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

/* hdl/cpu_memory_map.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_memory_map (
    input logic clock,
    input logic reset_n,

    input nes_bus_pkg::bus_req_t mem_cmd,
    input logic mem_strobe,
    output logic [7:0] mem_rdata,

    output nes_bus_pkg::ppu_port_t ppu,
    input logic [7:0] ppu_rdata,

    output logic dma_start,
    output logic [7:0] dma_page,

    input logic ctlr_data,
    output logic ctlr_pulse,
    output logic ctlr_latch
);

    typedef enum logic [1:0] {src_none, src_ram, src_ppu, src_pad} rd_src_t;

    logic [15:0] addr;
    logic is_ram;
    logic is_ppu;
    logic is_dma;
    logic is_pad;
    logic ram_we;
    logic [$clog2(nes_bus_pkg::ram_words)-1:0] ram_idx;
    logic [7:0] ram [nes_bus_pkg::ram_words];
    logic [7:0] ram_q;
    logic [7:0] ppu_q;
    logic pad_q;
    logic button_bit;
    rd_src_t rd_src;

    assign addr = mem_cmd.addr.flat;

    // Region decode
    assign is_ram = addr < nes_bus_pkg::ram_base_end;
    assign is_ppu = !is_ram && addr < nes_bus_pkg::ppu_base_end;
    assign is_dma = addr == nes_bus_pkg::oamdma_addr;
    assign is_pad = addr == nes_bus_pkg::joypad1_addr;

    // Low bits only, so the 2 KB repeats up to 2000h
    assign ram_idx = addr[$clog2(nes_bus_pkg::ram_words)-1:0];
    assign ram_we = mem_strobe && is_ram && mem_cmd.write;

    always_comb begin
        ppu.en = mem_strobe && is_ppu;
        ppu.write = mem_cmd.write;
        ppu.sel = nes_bus_pkg::ppu_reg_t'(addr[2:0]);
        ppu.wdata = mem_cmd.wdata;
    end

    assign dma_start = mem_strobe && is_dma && mem_cmd.write;
    assign dma_page = mem_cmd.wdata;

    always_ff @(posedge clock) begin
        if (ram_we) begin
            ram[ram_idx] <= mem_cmd.wdata;
        end
        ram_q <= ram[ram_idx];
        if (mem_strobe) begin
            ppu_q <= ppu_rdata;
            pad_q <= button_bit;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_src <= src_none;
        end else if (mem_strobe) begin
            if (mem_cmd.write) begin
                rd_src <= src_none;
            end else if (is_ram) begin
                rd_src <= src_ram;
            end else if (is_ppu) begin
                rd_src <= src_ppu;
            end else if (is_pad) begin
                rd_src <= src_pad;
            end else begin
                rd_src <= src_none;
            end
        end
    end

    // Unmapped and write accesses read back zero
    always_comb begin
        case (rd_src)
            src_ram: mem_rdata = ram_q;
            src_ppu: mem_rdata = ppu_q;
            src_pad: mem_rdata = {7'b0, pad_q};
            default: mem_rdata = 8'h00;
        endcase
    end

    ctlr_interface u_ctlr (
        .clock(clock),
        .reset_n(reset_n),
        .strobe(mem_strobe),
        .addr(addr),
        .write(mem_cmd.write),
        .wdata(mem_cmd.wdata),
        .ctlr_data(ctlr_data),
        .ctlr_pulse(ctlr_pulse),
        .ctlr_latch(ctlr_latch),
        .button_bit(button_bit)
    );

endmodule

`default_nettype wire

/* hdl/ctlr_interface.sv */
`timescale 1ns/1ns
`default_nettype none

module ctlr_interface (
    input logic clock,
    input logic reset_n,

    input logic strobe,
    input logic [15:0] addr,
    input logic write,
    input logic [7:0] wdata,

    input logic ctlr_data,
    output logic ctlr_pulse,
    output logic ctlr_latch,

    output logic button_bit
);

    typedef enum logic [2:0] {
        st_idle, st_wrote1, st_wrote0, st_pulse_lo, st_pulse_hi
    } state_t;

    state_t state;
    state_t next;
    logic pad_read;
    logic pad_write;
    logic [$clog2(nes_bus_pkg::ctlr_pulse_len+1)-1:0] cnt;
    logic cnt_done;
    logic [3:0] pulse_cnt;
    logic pending;

    assign pad_read = strobe && !write && addr == nes_bus_pkg::joypad1_addr;
    assign pad_write = strobe && write && addr == nes_bus_pkg::joypad1_addr;
    assign cnt_done = int'(cnt) == nes_bus_pkg::ctlr_pulse_len;

    assign ctlr_latch = (state == st_wrote1);
    assign ctlr_pulse = (state == st_pulse_hi);

    always_comb begin
        next = state;
        case (state)
            st_idle: next = st_idle;
            st_wrote1: begin
                if (pad_write && !wdata[0]) begin
                    next = st_wrote0;
                end
            end
            st_wrote0: begin
                if (pad_read) begin
                    next = st_pulse_lo;
                end
            end
            st_pulse_lo: begin
                if (cnt_done) begin
                    next = st_pulse_hi;
                end
            end
            st_pulse_hi: begin
                if (cnt_done) begin
                    if (pulse_cnt == 4'd8) begin
                        next = st_idle;
                    end else if (pending || pad_read) begin
                        next = st_pulse_lo;
                    end else begin
                        next = st_wrote0;
                    end
                end
            end
            default: next = st_idle;
        endcase
        // Writing 1 restarts the latch from any state
        if (pad_write && wdata[0]) begin
            next = st_wrote1;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
            cnt <= '0;
            pulse_cnt <= 4'd0;
            pending <= 1'b0;
        end else begin
            state <= next;
            if (next != state) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end

            if (next == st_wrote1) begin
                pulse_cnt <= 4'd0;
            end else if (next == st_pulse_hi && state != st_pulse_hi) begin
                pulse_cnt <= pulse_cnt + 4'd1;
            end

            // Reads that land mid-pulse are queued for the next one
            if (next == st_wrote1 || (next == st_pulse_lo && state != st_pulse_lo)) begin
                pending <= 1'b0;
            end else if (pad_read && (state == st_pulse_lo || state == st_pulse_hi)) begin
                pending <= 1'b1;
            end
        end
    end

    // Pad drives the line low for a pressed button
    always_ff @(posedge clock) begin
        button_bit <= ~ctlr_data;
    end

endmodule

`default_nettype wire

/* hdl/nes_bus_pkg.sv */
`default_nettype none

package nes_bus_pkg;

    // Work RAM and its mirrors
    localparam int ram_words = 2048;
    localparam logic [15:0] ram_base_end = 16'h2000;

    // PPU registers repeat every 8 bytes below this
    localparam logic [15:0] ppu_base_end = 16'h4000;

    localparam logic [15:0] oamdma_addr = 16'h4014;
    localparam logic [15:0] joypad1_addr = 16'h4016;

    // Cycles spent in each joypad pulse phase
    localparam int ctlr_pulse_len = 3;

    localparam int oam_dma_count = 256;

    typedef struct packed {
        logic [7:0] page;
        logic [7:0] offset;
    } bus_page_t;

    // Decoder reads the flat word, DMA builds page and offset
    typedef union packed {
        logic [15:0] flat;
        bus_page_t paged;
    } bus_addr_u;

    typedef struct packed {
        bus_addr_u addr;
        logic write;
        logic [7:0] wdata;
    } bus_req_t;

    typedef enum logic [2:0] {
        ppuctrl = 3'd0,
        ppumask = 3'd1,
        ppustatus = 3'd2,
        oamaddr = 3'd3,
        oamdata = 3'd4,
        ppuscroll = 3'd5,
        ppuaddr = 3'd6,
        ppudata = 3'd7
    } ppu_reg_t;

    typedef struct packed {
        logic en;
        logic write;
        ppu_reg_t sel;
        logic [7:0] wdata;
    } ppu_port_t;

endpackage

`default_nettype wire

/* hdl/nes_cpu_bus.sv */
`timescale 1ns/1ns
`default_nettype none

module nes_cpu_bus (
    input logic clock,
    input logic reset_n,

    input logic cpu_req,
    input nes_bus_pkg::bus_req_t cpu_cmd,
    output logic cpu_ack,
    output logic [7:0] cpu_rdata,

    output nes_bus_pkg::ppu_port_t ppu,
    input logic [7:0] ppu_rdata,

    input logic ctlr_data,
    output logic ctlr_pulse,
    output logic ctlr_latch,

    output logic dma_busy
);

    // DMA channel
    logic dma_req;
    nes_bus_pkg::bus_req_t dma_cmd;
    logic dma_ack;
    logic [7:0] dma_rdata;

    // Arbiter to memory map
    nes_bus_pkg::bus_req_t mem_cmd;
    logic mem_strobe;
    logic [7:0] mem_rdata;

    logic dma_start;
    logic [7:0] dma_page;

    bus_arbiter u_arbiter (
        .clock(clock),
        .reset_n(reset_n),
        .cpu_req(cpu_req),
        .cpu_cmd(cpu_cmd),
        .cpu_ack(cpu_ack),
        .cpu_rdata(cpu_rdata),
        .dma_req(dma_req),
        .dma_cmd(dma_cmd),
        .dma_ack(dma_ack),
        .dma_rdata(dma_rdata),
        .mem_cmd(mem_cmd),
        .mem_strobe(mem_strobe),
        .mem_rdata(mem_rdata)
    );

    cpu_memory_map u_memory_map (
        .clock(clock),
        .reset_n(reset_n),
        .mem_cmd(mem_cmd),
        .mem_strobe(mem_strobe),
        .mem_rdata(mem_rdata),
        .ppu(ppu),
        .ppu_rdata(ppu_rdata),
        .dma_start(dma_start),
        .dma_page(dma_page),
        .ctlr_data(ctlr_data),
        .ctlr_pulse(ctlr_pulse),
        .ctlr_latch(ctlr_latch)
    );

    oam_dma u_oam_dma (
        .clock(clock),
        .reset_n(reset_n),
        .dma_start(dma_start),
        .dma_page(dma_page),
        .req(dma_req),
        .cmd(dma_cmd),
        .ack(dma_ack),
        .rdata(dma_rdata),
        .busy(dma_busy)
    );

endmodule

`default_nettype wire

/* hdl/oam_dma.sv */
`timescale 1ns/1ns
`default_nettype none

module oam_dma (
    input logic clock,
    input logic reset_n,

    input logic dma_start,
    input logic [7:0] dma_page,

    output logic req,
    output nes_bus_pkg::bus_req_t cmd,
    input logic ack,
    input logic [7:0] rdata,

    output logic busy
);

    typedef enum logic [1:0] {st_idle, st_req, st_drop} state_t;

    state_t state;
    logic is_write;
    logic last_byte;
    logic [7:0] page_q;
    logic [7:0] offset_q;
    logic [7:0] data_q;
    nes_bus_pkg::bus_addr_u src_addr;

    assign busy = (state != st_idle);
    assign req = (state == st_req);
    assign last_byte = offset_q == 8'(nes_bus_pkg::oam_dma_count - 1);

    always_comb begin
        src_addr.paged.page = page_q;
        src_addr.paged.offset = offset_q;
        cmd.addr = src_addr;
        // Writes always go to OAMDATA at 2004h
        if (is_write) begin
            cmd.addr.flat = {nes_bus_pkg::ram_base_end[15:3], nes_bus_pkg::oamdata};
        end
        cmd.write = is_write;
        cmd.wdata = data_q;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
            is_write <= 1'b0;
            offset_q <= 8'd0;
        end else begin
            case (state)
                st_idle: begin
                    if (dma_start) begin
                        offset_q <= 8'd0;
                        is_write <= 1'b0;
                        state <= st_req;
                    end
                end
                st_req: begin
                    if (ack) begin
                        state <= st_drop;
                    end
                end
                st_drop: begin
                    // Wait for ack to fall before the next transaction
                    if (!ack) begin
                        if (!is_write) begin
                            is_write <= 1'b1;
                            state <= st_req;
                        end else if (last_byte) begin
                            is_write <= 1'b0;
                            state <= st_idle;
                        end else begin
                            is_write <= 1'b0;
                            offset_q <= offset_q + 8'd1;
                            state <= st_req;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_idle && dma_start) begin
            page_q <= dma_page;
        end
        if (state == st_req && ack && !is_write) begin
            data_q <= rdata;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
hdl/nes_bus_pkg.sv
hdl/ctlr_interface.sv
hdl/bus_arbiter.sv
hdl/cpu_memory_map.sv
hdl/oam_dma.sv
hdl/nes_cpu_bus.sv
bench/nes_bus_properties.sv
bench/tb_nes_cpu_bus.sv
